// File: Bender.yml
package:
  name: dataCache

sources:
  - design/cacheGeometryPkg.sv
  - design/cacheBusPkg.sv
  - design/spRam.sv
  - design/wayArray.sv
  - design/lineAccess.sv
  - design/burstEngine.sv
  - design/cacheController.sv
  - design/dataCache.sv
  - target: simulation
    files:
      - sim/dataCacheChecker.sv
      - sim/dataCacheTb.sv

// File: dataCache.f
design/cacheGeometryPkg.sv
design/cacheBusPkg.sv
design/spRam.sv
design/wayArray.sv
design/lineAccess.sv
design/burstEngine.sv
design/cacheController.sv
design/dataCache.sv
sim/dataCacheChecker.sv
sim/dataCacheTb.sv

// File: design/burstEngine.sv
`timescale 1ns/1ns

module burstEngine (
    input  logic clock,
    input  logic reset,
    input  logic writingBack,
    input  logic refilling,
    input  cacheGeometryPkg::lineType victimLine,
    input  logic wReady,
    input  logic rValid,
    input  logic rLast,
    input  cacheBusPkg::beatType rData,
    output logic wValid,
    output cacheBusPkg::beatType wData,
    output logic wLast,
    output logic rReady,
    output logic writebackDone,
    output logic refillDone,
    output cacheGeometryPkg::lineType refillLine
);

    // beat number inside the current burst
    logic [$clog2(cacheBusPkg::beatsPerLine)-1:0] beat;
    logic lastBeat;
    logic wFire;
    logic rFire;

    // earlier refill beats wait here
    cacheGeometryPkg::lineType lineBuffer;

    assign lastBeat = beat == cacheBusPkg::beatsPerLine - 1;

    // write side, one half of the victim per beat
    assign wValid = writingBack;
    assign wData = victimLine[beat*cacheBusPkg::beatWidth +: cacheBusPkg::beatWidth];
    assign wLast = writingBack && lastBeat;
    assign wFire = wValid && wReady;

    // read side
    assign rReady = refilling;
    assign rFire = rValid && rReady;

    // done pulses in the cycle of the last accepted beat
    assign writebackDone = wFire && wLast;
    assign refillDone = rFire && rLast;

    // write and refill never overlap so one counter serves both
    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= '0;
        end else if (writebackDone || refillDone) begin
            beat <= '0;
        end else if (wFire || rFire) begin
            beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rFire) begin
            lineBuffer[beat*cacheBusPkg::beatWidth +: cacheBusPkg::beatWidth] <= rData;
        end
    end

    // last beat bypasses the buffer
    // so the line is whole in the done cycle
    always_comb begin
        refillLine = lineBuffer;
        refillLine[beat*cacheBusPkg::beatWidth +: cacheBusPkg::beatWidth] = rData;
    end

endmodule

// File: design/cacheBusPkg.sv
package cacheBusPkg;

    // one memory beat is a full 64-bit word
    localparam int beatWidth = 64;

    typedef logic [beatWidth-1:0] beatType;

    // two beats fill one 16-byte line
    localparam int beatsPerLine = 2;

    // one enable bit per byte of a beat
    typedef logic [beatWidth/8-1:0] maskType;

    // the only store masks that change a line
    localparam maskType maskByte = 8'h01;
    localparam maskType maskHalf = 8'h03;
    localparam maskType maskWord = 8'h0f;
    localparam maskType maskDouble = 8'hff;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        writeBack,
        refill
    } stateType;

    // any nonzero value keeps the LFSR running
    localparam logic [15:0] lfsrSeed = 16'h0001;

endpackage

// File: design/cacheController.sv
`timescale 1ns/1ns

module cacheController (
    input  logic clock,
    input  logic reset,
    input  logic valid,
    input  logic op,
    input  cacheGeometryPkg::addrType addr,
    input  logic hit,
    input  cacheGeometryPkg::wayType hitWay,
    input  logic victimDirty,
    input  cacheGeometryPkg::tagType victimTag,
    input  cacheBusPkg::beatType loadData,
    input  logic arReady,
    input  logic awReady,
    input  logic writebackDone,
    input  logic refillDone,
    output logic arValid,
    output logic awValid,
    output cacheGeometryPkg::addrType arAddr,
    output cacheGeometryPkg::addrType awAddr,
    output logic writingBack,
    output logic refilling,
    output cacheGeometryPkg::wayType victimWay,
    output cacheGeometryPkg::wayType writeWay,
    output logic lineWrite,
    output logic fill,
    output logic markDirty,
    output logic selectRefill,
    output logic dataOk,
    output cacheBusPkg::beatType data
);

    cacheBusPkg::stateType state;
    cacheBusPkg::stateType nextState;

    logic [15:0] lfsr;
    // victim already written back during this miss
    logic victimWritten;
    logic needWriteBack;
    logic lookupHit;
    logic storeHit;

    cacheGeometryPkg::tagType reqTag;
    cacheGeometryPkg::indexType reqIndex;

    assign reqTag = addr[cacheGeometryPkg::addrWidth-1 -: cacheGeometryPkg::tagWidth];
    assign reqIndex = addr[cacheGeometryPkg::offsetWidth +: cacheGeometryPkg::indexWidth];

    assign lookupHit = state == cacheBusPkg::lookup && hit;
    assign storeHit = lookupHit && op;
    assign needWriteBack = victimDirty && !victimWritten;

    always_comb begin
        nextState = state;
        case (state)
            cacheBusPkg::idle:
                if (valid) nextState = cacheBusPkg::lookup;
            cacheBusPkg::lookup:
                nextState = hit ? cacheBusPkg::idle : cacheBusPkg::miss;
            cacheBusPkg::miss:
                // dirty victim goes out before the refill is requested
                if (needWriteBack && awReady) begin
                    nextState = cacheBusPkg::writeBack;
                end else if (!needWriteBack && arReady) begin
                    nextState = cacheBusPkg::refill;
                end
            cacheBusPkg::writeBack:
                if (writebackDone) nextState = cacheBusPkg::miss;
            cacheBusPkg::refill:
                // retry the lookup, it hits now
                if (refillDone) nextState = cacheBusPkg::lookup;
            default:
                nextState = cacheBusPkg::idle;
        endcase
    end

    // line-aligned bus addresses
    assign arAddr = {reqTag, reqIndex, {cacheGeometryPkg::offsetWidth{1'b0}}};
    assign awAddr = {victimTag, reqIndex, {cacheGeometryPkg::offsetWidth{1'b0}}};
    assign arValid = state == cacheBusPkg::miss && !needWriteBack;
    assign awValid = state == cacheBusPkg::miss && needWriteBack;

    assign writingBack = state == cacheBusPkg::writeBack;
    assign refilling = state == cacheBusPkg::refill;
    assign selectRefill = refilling;

    // array writes, refill into the victim or store into the hit way
    assign fill = refilling && refillDone;
    assign lineWrite = storeHit || fill;
    assign markDirty = storeHit;
    assign writeWay = refilling ? victimWay : hitWay;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= cacheBusPkg::idle;
            lfsr <= cacheBusPkg::lfsrSeed;
            victimWay <= '0;
            victimWritten <= 1'b0;
            dataOk <= 1'b0;
        end else begin
            state <= nextState;
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
            // pick the victim when the lookup misses
            if (state == cacheBusPkg::lookup && !hit) begin
                victimWay <= cacheGeometryPkg::wayType'(lfsr);
            end
            if (state == cacheBusPkg::lookup) begin
                victimWritten <= 1'b0;
            end else if (writebackDone) begin
                victimWritten <= 1'b1;
            end
            dataOk <= lookupHit;
        end
    end

    // response data
    always_ff @(posedge clock) begin
        if (lookupHit) begin
            data <= loadData;
        end
    end

endmodule

// File: design/cacheGeometryPkg.sv
package cacheGeometryPkg;

    // request and memory address width
    localparam int addrWidth = 64;

    // 16-byte lines
    localparam int offsetWidth = 4;

    // 16 sets
    localparam int indexWidth = 4;

    // everything above index and offset
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth;

    localparam int wayCount = 4;
    localparam int setCount = 1 << indexWidth;
    localparam int lineBytes = 1 << offsetWidth;

    typedef logic [addrWidth-1:0] addrType;
    typedef logic [tagWidth-1:0] tagType;
    typedef logic [indexWidth-1:0] indexType;
    typedef logic [offsetWidth-1:0] offsetType;

    // way number inside a set
    typedef logic [$clog2(wayCount)-1:0] wayType;

    // one whole cache line, byte 0 in the low bits
    typedef logic [lineBytes*8-1:0] lineType;

    // row of the valid and dirty bits, set in the upper bits
    typedef logic [indexWidth+$clog2(wayCount)-1:0] lineSlotType;

endpackage

// File: design/dataCache.sv
`timescale 1ns/1ns

module dataCache (
    input  logic clock,
    input  logic reset,
    input  logic valid,
    input  logic op,
    input  cacheGeometryPkg::addrType addr,
    input  cacheBusPkg::beatType storeData,
    input  cacheBusPkg::maskType storeMask,
    output logic dataOk,
    output cacheBusPkg::beatType loadData,
    output logic arValid,
    output cacheGeometryPkg::addrType arAddr,
    input  logic arReady,
    input  logic rValid,
    input  cacheBusPkg::beatType rData,
    input  logic rLast,
    output logic rReady,
    output logic awValid,
    output cacheGeometryPkg::addrType awAddr,
    input  logic awReady,
    output logic wValid,
    output cacheBusPkg::beatType wData,
    output logic wLast,
    input  logic wReady
);

    cacheGeometryPkg::lineType wayLines [cacheGeometryPkg::wayCount];
    cacheGeometryPkg::lineType mergedLine;
    cacheGeometryPkg::lineType refillLine;
    cacheGeometryPkg::lineType writeLine;
    cacheGeometryPkg::tagType victimTag;
    cacheGeometryPkg::wayType hitWay;
    cacheGeometryPkg::wayType victimWay;
    cacheGeometryPkg::wayType writeWay;
    cacheBusPkg::beatType lineLoadData;
    logic hit;
    logic victimDirty;
    logic lineWrite;
    logic fill;
    logic markDirty;
    logic selectRefill;
    logic writingBack;
    logic refilling;
    logic writebackDone;
    logic refillDone;

    // refill line or merged store line into the array
    assign writeLine = selectRefill ? refillLine : mergedLine;

    wayArray wayArray_i (
        .clock(clock),
        .reset(reset),
        .setIndex(addr[cacheGeometryPkg::offsetWidth +: cacheGeometryPkg::indexWidth]),
        .lookupTag(addr[cacheGeometryPkg::addrWidth-1 -: cacheGeometryPkg::tagWidth]),
        .victimWay(victimWay),
        .writeWay(writeWay),
        .lineWrite(lineWrite),
        .writeLine(writeLine),
        .fill(fill),
        .markDirty(markDirty),
        .wayLines(wayLines),
        .hit(hit),
        .hitWay(hitWay),
        .victimTag(victimTag),
        .victimDirty(victimDirty)
    );

    // hit way feeds load and store
    lineAccess lineAccess_i (
        .line(wayLines[hitWay]),
        .offset(addr[cacheGeometryPkg::offsetWidth-1:0]),
        .storeData(storeData),
        .storeMask(storeMask),
        .loadData(lineLoadData),
        .mergedLine(mergedLine)
    );

    // victim way feeds the write-back
    burstEngine burstEngine_i (
        .clock(clock),
        .reset(reset),
        .writingBack(writingBack),
        .refilling(refilling),
        .victimLine(wayLines[victimWay]),
        .wReady(wReady),
        .rValid(rValid),
        .rLast(rLast),
        .rData(rData),
        .wValid(wValid),
        .wData(wData),
        .wLast(wLast),
        .rReady(rReady),
        .writebackDone(writebackDone),
        .refillDone(refillDone),
        .refillLine(refillLine)
    );

    cacheController cacheController_i (
        .clock(clock),
        .reset(reset),
        .valid(valid),
        .op(op),
        .addr(addr),
        .hit(hit),
        .hitWay(hitWay),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .loadData(lineLoadData),
        .arReady(arReady),
        .awReady(awReady),
        .writebackDone(writebackDone),
        .refillDone(refillDone),
        .arValid(arValid),
        .awValid(awValid),
        .arAddr(arAddr),
        .awAddr(awAddr),
        .writingBack(writingBack),
        .refilling(refilling),
        .victimWay(victimWay),
        .writeWay(writeWay),
        .lineWrite(lineWrite),
        .fill(fill),
        .markDirty(markDirty),
        .selectRefill(selectRefill),
        .dataOk(dataOk),
        .data(loadData)
    );

endmodule

// File: design/lineAccess.sv
`timescale 1ns/1ns

module lineAccess (
    input  cacheGeometryPkg::lineType line,
    input  cacheGeometryPkg::offsetType offset,
    input  cacheBusPkg::beatType storeData,
    input  cacheBusPkg::maskType storeMask,
    output cacheBusPkg::beatType loadData,
    output cacheGeometryPkg::lineType mergedLine
);

    typedef logic [cacheGeometryPkg::lineBytes-1:0] enableType;

    cacheGeometryPkg::lineType loadShifted;
    cacheGeometryPkg::lineType storeShifted;
    enableType byteEnable;

    // load, bytes past the line end read as zero
    assign loadShifted = line >> {offset, 3'b000};
    assign loadData = loadShifted[cacheBusPkg::beatWidth-1:0];

    always_comb begin
        // only low-aligned 1, 2, 4 and 8 byte masks write anything
        case (storeMask)
            cacheBusPkg::maskByte, cacheBusPkg::maskHalf,
            cacheBusPkg::maskWord, cacheBusPkg::maskDouble:
                byteEnable = enableType'(storeMask) << offset;
            default:
                byteEnable = '0;
        endcase
        storeShifted = cacheGeometryPkg::lineType'(storeData) << {offset, 3'b000};
        // byte-wise merge into the old line
        for (int b = 0; b < cacheGeometryPkg::lineBytes; b++) begin
            mergedLine[b*8 +: 8] = byteEnable[b] ? storeShifted[b*8 +: 8] : line[b*8 +: 8];
        end
    end

endmodule

// File: design/spRam.sv
`timescale 1ns/1ns

module spRam #(
    parameter type wordType = logic [31:0],
    parameter int depth = 16
) (
    input  logic clock,
    input  logic writeEnable,
    input  logic [$clog2(depth)-1:0] address,
    input  wordType writeData,
    output wordType readData
);

    wordType memory [depth];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memory[address] <= writeData;
            // write-first, new word shows up on the next cycle
            readData <= writeData;
        end else begin
            readData <= memory[address];
        end
    end

endmodule

// File: design/wayArray.sv
`timescale 1ns/1ns

module wayArray (
    input  logic clock,
    input  logic reset,
    input  cacheGeometryPkg::indexType setIndex,
    input  cacheGeometryPkg::tagType lookupTag,
    input  cacheGeometryPkg::wayType victimWay,
    input  cacheGeometryPkg::wayType writeWay,
    input  logic lineWrite,
    input  cacheGeometryPkg::lineType writeLine,
    input  logic fill,
    input  logic markDirty,
    output cacheGeometryPkg::lineType wayLines [cacheGeometryPkg::wayCount],
    output logic hit,
    output cacheGeometryPkg::wayType hitWay,
    output cacheGeometryPkg::tagType victimTag,
    output logic victimDirty
);

    // stored tag of every way in the addressed set
    cacheGeometryPkg::tagType tagRead [cacheGeometryPkg::wayCount];

    // one bit per set and way
    logic [cacheGeometryPkg::setCount*cacheGeometryPkg::wayCount-1:0] validBits;
    logic [cacheGeometryPkg::setCount*cacheGeometryPkg::wayCount-1:0] dirtyBits;

    cacheGeometryPkg::lineSlotType writeSlot;
    cacheGeometryPkg::lineSlotType victimSlot;

    assign writeSlot = {setIndex, writeWay};
    assign victimSlot = {setIndex, victimWay};

    // all ways of the set are read in parallel
    for (genvar w = 0; w < cacheGeometryPkg::wayCount; w++) begin : gWay
        // tag only changes on a refill
        spRam #(
            .wordType(cacheGeometryPkg::tagType),
            .depth(cacheGeometryPkg::setCount)
        ) tagRam (
            .clock(clock),
            .writeEnable(fill && writeWay == cacheGeometryPkg::wayType'(w)),
            .address(setIndex),
            .writeData(lookupTag),
            .readData(tagRead[w])
        );

        // line changes on a refill or a store hit
        spRam #(
            .wordType(cacheGeometryPkg::lineType),
            .depth(cacheGeometryPkg::setCount)
        ) lineRam (
            .clock(clock),
            .writeEnable(lineWrite && writeWay == cacheGeometryPkg::wayType'(w)),
            .address(setIndex),
            .writeData(writeLine),
            .readData(wayLines[w])
        );
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (fill) begin
            // refilled line is always clean
            validBits[writeSlot] <= 1'b1;
            dirtyBits[writeSlot] <= 1'b0;
        end else if (markDirty) begin
            dirtyBits[writeSlot] <= 1'b1;
        end
    end

    // tag compare, highest matching way wins
    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < cacheGeometryPkg::wayCount; w++) begin
            if (validBits[{setIndex, cacheGeometryPkg::wayType'(w)}] &&
                tagRead[w] == lookupTag) begin
                hit = 1'b1;
                hitWay = cacheGeometryPkg::wayType'(w);
            end
        end
    end

    // victim status for the write-back decision
    assign victimTag = tagRead[victimWay];
    assign victimDirty = validBits[victimSlot] && dirtyBits[victimSlot];

endmodule

// File: sim/dataCacheChecker.sv
`timescale 1ns/1ns

module dataCacheChecker (
    input logic clock,
    input logic reset,
    input cacheGeometryPkg::addrType addr,
    input logic dataOk,
    input cacheBusPkg::beatType loadData,
    input logic expectLoad,
    input cacheBusPkg::beatType expected,
    input cacheBusPkg::beatType writeExpected,
    input logic storeSeen,
    input logic arValid,
    input logic arReady,
    input cacheGeometryPkg::addrType arAddr,
    input logic awValid,
    input logic awReady,
    input cacheGeometryPkg::addrType awAddr,
    input logic wValid,
    input logic wReady,
    input logic wLast,
    input cacheBusPkg::beatType wData,
    input logic rValid,
    input logic rReady,
    input logic rLast
);

    string testName = "none";
    int testErrors = 0;
    int errorCount = 0;
    int testCount = 0;
    int failedTests = 0;
    // beats seen in the open write burst
    int wBeats = 0;
    logic awOpen = 1'b0;
    logic arOpen = 1'b0;

    task automatic valueError(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("Error %s: %s expected %0h, actual %0h", testName, what, exp, act);
        testErrors++;
        errorCount++;
    endtask

    task automatic ruleError(input string what);
        $display("%s: %s", testName, what);
        testErrors++;
        errorCount++;
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic compareLatency(input int exp, input int act);
        if (exp != act) begin
            valueError("dataOk latency", exp, act);
        end
    endtask

    task automatic endTest();
        testCount++;
        if (testErrors == 0) begin
            $display("test %s passed", testName);
        end else begin
            failedTests++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end
    endtask

    task automatic report();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 testCount, testCount - failedTests, failedTests, errorCount);
    endtask

    function automatic int totalErrors();
        return errorCount;
    endfunction

    // all ports sampled at the rising edge before the DUT updates
    always @(posedge clock) begin
        if (!reset) begin
            // load response against the reference
            if (dataOk && expectLoad && loadData !== expected) begin
                valueError("loadData", expected, loadData);
            end
            // valid drops once the address is taken
            if (arValid && arOpen) begin
                ruleError("arValid still high while a refill is open");
            end
            if (awValid && awOpen) begin
                ruleError("awValid still high while a write burst is open");
            end
            // refill request carries the line base of the request
            if (arValid && arReady) begin
                if (arAddr[3:0] != 4'h0) begin
                    ruleError("ar address is not line-aligned");
                end
                if (arAddr !== {addr[63:4], 4'h0}) begin
                    valueError("arAddr", {addr[63:4], 4'h0}, arAddr);
                end
                arOpen = 1'b1;
            end
            // write-back needs a dirty line and thus an earlier store
            if (awValid && awReady) begin
                if (awAddr[3:0] != 4'h0) begin
                    ruleError("aw address is not line-aligned");
                end
                if (!storeSeen) begin
                    ruleError("write-back started before any store");
                end
                awOpen = 1'b1;
            end
            // no write beats outside a write burst
            if (wValid && !awOpen) begin
                ruleError("wValid high with no write address taken");
            end
            // two write beats with last on the second
            if (wValid && wReady) begin
                if (wData !== writeExpected) begin
                    valueError("wData", writeExpected, wData);
                end
                if (wLast !== (wBeats == 1)) begin
                    valueError("wLast", wBeats == 1, wLast);
                end
                wBeats++;
                if (wLast) begin
                    awOpen = 1'b0;
                    wBeats = 0;
                end
            end
            // rReady only inside a refill
            if (rReady && !arOpen) begin
                ruleError("rReady high with no refill open");
            end
            if (rValid && rReady && rLast) begin
                arOpen = 1'b0;
            end
        end
    end

endmodule

// File: sim/dataCacheTb.sv
`timescale 1ns/1ns

module dataCacheTb;

    // 64 KiB memory window under a fixed upper part
    localparam cacheGeometryPkg::addrType memBase = 64'h0000_7f3c_9e20_0000;
    localparam int memSize = 65536;

    // loop counts per test
    localparam int readMissCount = 6;
    localparam int storeCount = 8;
    localparam int badMaskCount = 2;
    localparam int evictCount = 6;
    localparam int randomCount = 40;
    localparam int requestTotal = readMissCount * 2 + storeCount * 3 + badMaskCount * 3
                                  + evictCount * 2 + randomCount;
    // worst miss with write-back and slow memory stays well under 40
    localparam int cycleLimit = requestTotal * 40 + 200;

    logic clock;
    logic reset;
    logic valid;
    logic op;
    cacheGeometryPkg::addrType addr;
    cacheBusPkg::beatType storeData;
    cacheBusPkg::maskType storeMask;
    logic dataOk;
    cacheBusPkg::beatType loadData;
    logic arValid;
    cacheGeometryPkg::addrType arAddr;
    logic arReady;
    logic rValid;
    cacheBusPkg::beatType rData;
    logic rLast;
    logic rReady;
    logic awValid;
    cacheGeometryPkg::addrType awAddr;
    logic awReady;
    logic wValid;
    cacheBusPkg::beatType wData;
    logic wLast;
    logic wReady;

    // reference side
    cacheBusPkg::beatType expected;
    cacheBusPkg::beatType writeExpected;
    logic expectLoad;
    logic storeSeen;
    int lastLatency;
    int cycles = 0;

    // memory behind the cache and the coherent mirror
    logic [7:0] memBytes [memSize];
    logic [7:0] mirror [memSize];

    dataCache dataCache_i (.*);

    dataCacheChecker checks (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // reset contents depend on every address bit
    function automatic logic [7:0] fillByte(input cacheGeometryPkg::addrType a);
        logic [7:0] folded;
        folded = 8'h3c;
        for (int i = 0; i < 8; i++) begin
            folded = {folded[6:0], folded[7]} ^ a[i*8 +: 8];
        end
        return folded;
    endfunction

    // load result is the line shifted by offset with zeros past the line end
    function automatic cacheBusPkg::beatType expectedLoad(input cacheGeometryPkg::addrType a);
        cacheBusPkg::beatType result;
        int offset;
        int lineStart;
        result = '0;
        offset = int'(a[3:0]);
        lineStart = int'(a[15:0]) - offset;
        for (int i = 0; i < 8; i++) begin
            if (offset + i < 16) begin
                result[i*8 +: 8] = mirror[lineStart + offset + i];
            end
        end
        return result;
    endfunction

    // only 1, 3, 0F and FF masks change bytes
    function automatic void updateMirror(input cacheGeometryPkg::addrType a,
                                         input cacheBusPkg::beatType d,
                                         input cacheBusPkg::maskType m);
        int count;
        case (m)
            8'h01: count = 1;
            8'h03: count = 2;
            8'h0f: count = 4;
            8'hff: count = 8;
            default: count = 0;
        endcase
        for (int i = 0; i < count; i++) begin
            if (int'(a[3:0]) + i < 16) begin
                mirror[int'(a[15:0]) + i] = d[i*8 +: 8];
            end
        end
    endfunction

    function automatic cacheGeometryPkg::addrType makeAddr(input int tagNum, input int setNum,
                                                           input int offset);
        return memBase + tagNum * 256 + setNum * 16 + offset;
    endfunction

    task automatic idleCycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    // one request held until dataOk
    task automatic request(input logic isStore, input cacheGeometryPkg::addrType a,
                           input cacheBusPkg::beatType d, input cacheBusPkg::maskType m);
        @(negedge clock);
        valid = 1'b1;
        op = isStore;
        addr = a;
        storeData = d;
        storeMask = m;
        expected = expectedLoad(a);
        expectLoad = !isStore;
        if (isStore) begin
            storeSeen = 1'b1;
            updateMirror(a, d, m);
        end
        lastLatency = 1;
        @(negedge clock);
        valid = 1'b0;
        while (!dataOk) begin
            @(negedge clock);
            lastLatency++;
        end
    endtask

    // last compare lands on the next rising edge
    task automatic closeTest();
        repeat (2) @(negedge clock);
        checks.endTest();
    endtask

    // read side of the memory with a random delay before ar and each beat
    initial begin : readResponder
        int lineStart;
        arReady = 1'b0;
        rValid = 1'b0;
        rLast = 1'b0;
        rData = '0;
        forever begin
            @(negedge clock);
            if (arValid) begin
                idleCycles($urandom_range(3));
                lineStart = int'(arAddr[15:0]);
                arReady = 1'b1;
                @(negedge clock);
                arReady = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    idleCycles($urandom_range(3));
                    rValid = 1'b1;
                    rLast = b == 1;
                    for (int i = 0; i < 8; i++) begin
                        rData[i*8 +: 8] = memBytes[lineStart + b * 8 + i];
                    end
                    while (!rReady) @(negedge clock);
                    @(negedge clock);
                    rValid = 1'b0;
                    rLast = 1'b0;
                end
            end
        end
    end

    // write side takes the victim beats into memory
    initial begin : writeResponder
        int lineStart;
        awReady = 1'b0;
        wReady = 1'b0;
        writeExpected = '0;
        for (int i = 0; i < memSize; i++) begin
            memBytes[i] = fillByte(memBase + i);
        end
        forever begin
            @(negedge clock);
            if (awValid) begin
                idleCycles($urandom_range(3));
                lineStart = int'(awAddr[15:0]);
                awReady = 1'b1;
                @(negedge clock);
                awReady = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    idleCycles($urandom_range(3));
                    // victim beat as the mirror holds it
                    for (int i = 0; i < 8; i++) begin
                        writeExpected[i*8 +: 8] = mirror[lineStart + b * 8 + i];
                    end
                    wReady = 1'b1;
                    while (!wValid) @(negedge clock);
                    for (int i = 0; i < 8; i++) begin
                        memBytes[lineStart + b * 8 + i] = wData[i*8 +: 8];
                    end
                    @(negedge clock);
                    wReady = 1'b0;
                end
            end
        end
    end

    // run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles == cycleLimit) begin
            $display("run stopped, no end after %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int size;
        int setNum;
        logic isStore;
        cacheGeometryPkg::addrType a;
        cacheBusPkg::maskType m;
        void'($urandom(32'h5ecf));
        reset = 1'b1;
        valid = 1'b0;
        op = 1'b0;
        addr = memBase;
        storeData = '0;
        storeMask = '0;
        expected = '0;
        expectLoad = 1'b0;
        storeSeen = 1'b0;
        lastLatency = 0;
        for (int i = 0; i < memSize; i++) begin
            mirror[i] = fillByte(memBase + i);
        end
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // one set crowded with clean lines and each load repeated as a two-cycle hit
        checks.startTest("readMiss");
        setNum = $urandom_range(15);
        for (int k = 0; k < readMissCount; k++) begin
            a = makeAddr($urandom_range(255), setNum, $urandom_range(8));
            request(1'b0, a, '0, '0);
            request(1'b0, a, '0, '0);
            checks.compareLatency(2, lastLatency);
        end
        closeTest();

        // 1, 2, 4 and 8 byte stores with the whole line read back
        checks.startTest("storeMasks");
        for (int k = 0; k < storeCount; k++) begin
            size = 1 << (k % 4);
            m = 8'hff >> (8 - size);
            a = makeAddr($urandom_range(255), $urandom_range(15), $urandom_range(16 - size));
            request(1'b1, a, {$urandom, $urandom}, m);
            request(1'b0, {a[63:4], 4'h0}, '0, '0);
            request(1'b0, {a[63:4], 4'h8}, '0, '0);
        end
        closeTest();

        // odd masks complete but change nothing
        checks.startTest("badMask");
        for (int k = 0; k < badMaskCount; k++) begin
            a = makeAddr($urandom_range(255), $urandom_range(15), $urandom_range(8));
            request(1'b0, a, '0, '0);
            request(1'b1, a, {$urandom, $urandom}, k == 0 ? 8'h05 : 8'h3c);
            request(1'b0, a, '0, '0);
        end
        closeTest();

        // six tags into one 4-way set
        checks.startTest("eviction");
        setNum = $urandom_range(15);
        for (int k = 0; k < evictCount; k++) begin
            request(1'b1, makeAddr(k * 41 + 7, setNum, 0), {$urandom, $urandom}, 8'hff);
        end
        for (int k = 0; k < evictCount; k++) begin
            request(1'b0, makeAddr(k * 41 + 7, setNum, 0), '0, '0);
        end
        closeTest();

        // mixed traffic on two crowded sets
        checks.startTest("randomTraffic");
        for (int k = 0; k < randomCount; k++) begin
            isStore = $urandom_range(1);
            size = isStore ? 1 << $urandom_range(3) : 8;
            m = ($urandom_range(7) == 0) ? 8'h05 : 8'hff >> (8 - size);
            a = makeAddr($urandom_range(7) * 16, $urandom_range(1), $urandom_range(16 - size));
            request(isStore, a, {$urandom, $urandom}, m);
        end
        closeTest();

        checks.report();
        if (checks.totalErrors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
